// File: tests/mmio_patterns.txt
# columns: op addr data expected, all hex, unused columns 0.
# lcg: data = word count. burst: expected = pushes that fit. rdseq: expected = entry count.
read  ff000100 0 0
read  ff000104 0 0
read  ff000600 0 0
read  ff000604 0 0
lcg   00000100 20 0
write 00001010 deadbeef 0
read  00000010 0 deadbeef
write fefffffc 5a5aa5a5 0
read  00000ffc 0 5a5aa5a5
burst ff000000 40 10
read  ff000100 0 10
wait  ff000104 0 10
read  ff000604 0 10
rdseq ff000200 40 10
write ff000000 abcd00c3 0
write ff000000 0f 0
write ff000000 a5 0
wait  ff000104 0 13
read  ff000100 0 13
read  ff000600 0 13
read  ff000604 0 13
read  ff000240 0 c3
read  ff000244 0 0f
read  ff000248 0 a5

// File: mmio_subsystem.f
hdl/mmio_pkg.sv
hdl/uart_pkg.sv
hdl/mem_map_decoder.sv
hdl/ram_store.sv
hdl/uart_tx_queue.sv
hdl/uart_rx_buffer.sv
hdl/mmio_subsystem.sv
tests/mmio_subsystem_asserts.sv
tests/mmio_subsystem_tb.sv

// File: tests/mmio_subsystem_tb.sv
module mmio_subsystem_tb import mmio_pkg::*, uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_words    = 1024;
    localparam int clks_per_bit = 8;

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    bus_cmd_t host_cmd = '0;
    bus_rsp_t host_rsp;
    logic     uart_tx;
    logic     uart_rx;

    string    pat_op[$];
    addr_t    pat_addr[$];
    word_t    pat_data[$];
    word_t    pat_exp[$];
    word_t    lcg_state = 32'hf3ea;
    int       cycle_cnt = 0;
    int       cycle_limit = 0;

    // loopback with the line held idle in reset.
    assign uart_rx = rst_n ? uart_tx : 1'b1;

    always #2 clk = ~clk;

    mmio_subsystem #(.mem_words(mem_words), .clks_per_bit(clks_per_bit)) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_cmd (host_cmd),
        .host_rsp (host_rsp),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the patterns did not complete", cycle_cnt);
            $display("test failed");
            $fatal(1);
        end
    end

    // ##################################################
    // helpers.
    // ##################################################

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bus_cmd_t make_cmd(input logic write, input addr_t addr,
                                          input word_t wdata);
        bus_cmd_t c;
        c.start = 1'b1;
        c.write = write;
        c.addr  = addr;
        c.wdata = wdata;
        return c;
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // drive a command and hold it until ready.
    task automatic issue_cmd(input bus_cmd_t cmd);
        @(posedge clk);
        host_cmd <= cmd;
        @(negedge clk);
        while (!host_rsp.ready) begin
            @(negedge clk);
        end
    endtask

    task automatic bus_write(input addr_t addr, input word_t data);
        issue_cmd(make_cmd(1'b1, addr, data));
        @(posedge clk);
        host_cmd <= '0;
    endtask

    task automatic bus_read(input addr_t addr, output word_t data);
        issue_cmd(make_cmd(1'b0, addr, '0));
        @(posedge clk);
        host_cmd <= '0;
        @(negedge clk);  // one cycle after accept.
        check_value($sformatf("rdata_valid for %h", addr), 32'd1,
                    word_t'(host_rsp.rdata_valid));
        data = host_rsp.rdata;
    endtask

    task automatic load_patterns();
        int    fd;
        string line;
        string op;
        addr_t addr;
        word_t data;
        word_t expv;
        fd = $fopen("tests/mmio_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open the pattern file tests/mmio_patterns.txt");
            $display("test failed");
            $fatal(1);
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %h %h %h", op, addr, data, expv) != 4) begin
                    $display("malformed pattern line: %s", line);
                    $display("test failed");
                    $fatal(1);
                end
                pat_op.push_back(op);
                pat_addr.push_back(addr);
                pat_data.push_back(data);
                pat_exp.push_back(expv);
            end
        end
        $fclose(fd);
    endtask

    // ##################################################
    // pattern ops.
    // ##################################################

    task automatic run_pattern(input int idx);
        string op;
        string name;
        addr_t addr;
        word_t data;
        word_t expv;
        word_t got;
        word_t vals[$];
        int    i;
        op   = pat_op[idx];
        addr = pat_addr[idx];
        data = pat_data[idx];
        expv = pat_exp[idx];
        name = $sformatf("pattern %0d %s %h", idx, op, addr);
        if (op == "write") begin
            bus_write(addr, data);
        end else if (op == "read") begin
            bus_read(addr, got);
            check_value(name, expv, got);
        end else if (op == "wait") begin
            do begin
                bus_read(addr, got);  // poll until the value arrives.
            end while (got !== expv);
        end else if (op == "lcg") begin
            for (i = 0; i < int'(data); i++) begin
                lcg_state = lcg_next(lcg_state);
                vals.push_back(lcg_state);
                bus_write(addr + 4 * i, lcg_state);
            end
            for (i = 0; i < int'(data); i++) begin
                bus_read(addr + 4 * i, got);
                check_value($sformatf("%s word %0d", name, i), vals[i], got);
            end
        end else if (op == "burst") begin
            // one push per cycle so the last one meets a full queue.
            for (i = 0; i <= int'(expv); i++) begin
                @(posedge clk);
                host_cmd <= make_cmd(1'b1, addr, data + i);
                @(negedge clk);
                check_value($sformatf("%s ready %0d", name, i), word_t'(i < int'(expv)),
                            word_t'(host_rsp.ready));
                if (i == 2) begin
                    // first push accepted one edge ago.
                    check_value($sformatf("%s start bit", name), 32'd0, word_t'(uart_tx));
                end
            end
            @(posedge clk);
            host_cmd <= '0;  // refused push withdrawn.
        end else if (op == "rdseq") begin
            for (i = 0; i < int'(expv); i++) begin
                bus_read(addr + 4 * i, got);
                check_value($sformatf("%s entry %0d", name, i), data + i, got);
            end
        end else begin
            $display("unknown op %s in pattern %0d", op, idx);
            $display("test failed");
            $fatal(1);
        end
    endtask

    initial begin
        int k;
        load_patterns();
        cycle_limit = pat_op.size() * 2 + 40 * frame_bits * clks_per_bit + 100;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("uart_tx after reset", 32'd1, word_t'(uart_tx));
        check_value("rdata_valid after reset", 32'd0, word_t'(host_rsp.rdata_valid));
        for (k = 0; k < pat_op.size(); k++) begin
            run_pattern(k);
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: tests/mmio_subsystem_asserts.sv
module mmio_subsystem_asserts import mmio_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input bus_cmd_t host_cmd,
    input bus_rsp_t host_rsp,
    input bus_cmd_t ram_cmd,
    input bus_cmd_t tx_cmd,
    input bus_cmd_t rx_cmd
);

    timeunit 1ns;
    timeprecision 1ps;

    logic read_accept;

    assign read_accept = host_cmd.start && !host_cmd.write && host_rsp.ready;

    // response pulse only one cycle after an accepted read.
    valid_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_rsp.rdata_valid |-> $past(read_accept))
        else $error("rdata_valid without a read accepted one cycle before");

    read_gets_valid: assert property (@(posedge clk) disable iff (!rst_n)
        read_accept |=> host_rsp.rdata_valid)
        else $error("accepted read got no rdata_valid pulse");

    one_target: assert property (@(posedge clk)
        $onehot0({ram_cmd.start, tx_cmd.start, rx_cmd.start}))
        else $error("more than one target got start");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(ram_cmd.start || tx_cmd.start || rx_cmd.start))
        else $error("a target got start while in reset");

endmodule

bind mem_map_decoder mmio_subsystem_asserts asserts_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_cmd (host_cmd),
    .host_rsp (host_rsp),
    .ram_cmd  (ram_cmd),
    .tx_cmd   (tx_cmd),
    .rx_cmd   (rx_cmd)
);

// File: hdl/mmio_subsystem.sv
module mmio_subsystem import mmio_pkg::*; #(
    parameter int mem_words    = 1024,
    parameter int clks_per_bit = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t host_cmd,
    output bus_rsp_t host_rsp,
    input  logic     uart_rx,
    output logic     uart_tx
);

    // per target command and response.
    bus_cmd_t ram_cmd;
    bus_cmd_t tx_cmd;
    bus_cmd_t rx_cmd;
    bus_rsp_t ram_rsp;
    bus_rsp_t tx_rsp;
    bus_rsp_t rx_rsp;

    mem_map_decoder decoder_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_cmd (host_cmd),
        .host_rsp (host_rsp),
        .ram_cmd  (ram_cmd),
        .tx_cmd   (tx_cmd),
        .rx_cmd   (rx_cmd),
        .ram_rsp  (ram_rsp),
        .tx_rsp   (tx_rsp),
        .rx_rsp   (rx_rsp)
    );

    ram_store #(.mem_words(mem_words)) ram_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cmd   (ram_cmd),
        .rsp   (ram_rsp)
    );

    uart_tx_queue #(.clks_per_bit(clks_per_bit)) tx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (tx_cmd),
        .rsp     (tx_rsp),
        .uart_tx (uart_tx)
    );

    uart_rx_buffer #(.clks_per_bit(clks_per_bit)) rx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (rx_cmd),
        .rsp     (rx_rsp),
        .uart_rx (uart_rx)
    );

endmodule

// File: hdl/uart_rx_buffer.sv
module uart_rx_buffer import mmio_pkg::*, uart_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp,
    input  logic     uart_rx
);

    localparam int n_data  = frame_bits - 2;
    localparam int idx_w   = $clog2(n_data);
    localparam int tmr_w   = $clog2(clks_per_bit + 1);
    localparam int mid_bit = (clks_per_bit - 1) / 2;

    uart_byte_t       buf_q [256];
    logic [7:0]       tail_q;     // wraps at 256.
    word_t            count_q;
    logic [1:0]       sync_q;
    logic             rx_s;
    line_state_e      state_q;
    logic [tmr_w-1:0] timer_q;
    logic [idx_w-1:0] bit_idx_q;
    uart_byte_t       shift_q;
    logic             store_q;    // good byte waiting.
    logic             do_read;
    word_t            rdata_q;
    logic             valid_q;

    assign rx_s    = sync_q[1];
    assign do_read = cmd.start && !cmd.write;

    // ##################################################
    // deserializer.
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q    <= 2'b11;
            state_q   <= idle;
            timer_q   <= '0;
            bit_idx_q <= '0;
            store_q   <= 1'b0;
        end else begin
            sync_q  <= {sync_q[0], uart_rx};
            store_q <= 1'b0;
            timer_q <= timer_q + 1'b1;
            case (state_q)
                idle: begin
                    timer_q <= '0;
                    if (!rx_s) begin
                        state_q <= start_bit;
                    end
                end
                start_bit: begin
                    if (timer_q == tmr_w'(mid_bit)) begin
                        timer_q   <= '0;
                        bit_idx_q <= '0;
                        // glitch if the line is back high.
                        state_q   <= rx_s ? idle : data_bits;
                    end
                end
                data_bits: begin
                    if (timer_q == tmr_w'(clks_per_bit - 1)) begin
                        timer_q <= '0;
                        shift_q <= {rx_s, shift_q[7:1]};
                        if (bit_idx_q == idx_w'(n_data - 1)) begin
                            state_q <= stop_bit;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    if (timer_q == tmr_w'(clks_per_bit - 1)) begin
                        state_q <= idle;
                        store_q <= rx_s;  // low stop bit drops the byte.
                    end
                end
            endcase
        end
    end

    // ##################################################
    // circular store and bus side.
    // ##################################################

    always_ff @(posedge clk) begin
        if (store_q) begin
            buf_q[tail_q] <= shift_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= do_read;
            if (store_q) begin
                tail_q  <= tail_q + 1'b1;
                count_q <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            if (cmd.addr < uart_rx_tail_ofs) begin
                rdata_q <= {24'b0, buf_q[cmd.addr[9:2]]};  // one byte per word.
            end else if (cmd.addr == uart_rx_tail_ofs) begin
                rdata_q <= {24'b0, tail_q};
            end else if (cmd.addr == uart_rx_count_ofs) begin
                rdata_q <= count_q;
            end else begin
                rdata_q <= '0;
            end
        end
    end

    assign rsp = '{ready: 1'b1, rdata: rdata_q, rdata_valid: valid_q};

endmodule

// File: hdl/uart_tx_queue.sv
module uart_tx_queue import mmio_pkg::*, uart_pkg::*; #(
    parameter int clks_per_bit = 8
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp,
    output logic     uart_tx
);

    localparam int ptr_bits = 4;
    localparam int depth    = 1 << ptr_bits;
    localparam int n_data   = frame_bits - 2;
    localparam int idx_w    = $clog2(n_data);
    localparam int tmr_w    = $clog2(clks_per_bit + 1);

    uart_byte_t       fifo_q [depth];
    word_t            tail_q;      // bytes pushed.
    word_t            head_q;      // bytes fully sent.
    logic             full;
    logic             push;
    logic             do_read;
    word_t            rdata_q;
    logic             valid_q;
    line_state_e      state_q;
    logic [tmr_w-1:0] timer_q;
    logic [idx_w-1:0] bit_idx_q;
    uart_byte_t       shift_q;
    logic             tx_q;
    logic             bit_done;

    // the byte on the line keeps its slot until the stop bit ends.
    assign full     = (tail_q - head_q) == word_t'(depth);
    assign push     = cmd.start && cmd.write && (cmd.addr == '0) && !full;
    assign do_read  = cmd.start && !cmd.write;
    assign bit_done = timer_q == tmr_w'(clks_per_bit - 1);

    // ##################################################
    // queue and bus side.
    // ##################################################

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_q[tail_q[ptr_bits-1:0]] <= cmd.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            case (cmd.addr)
                uart_tx_tail_ofs: rdata_q <= tail_q;
                uart_tx_head_ofs: rdata_q <= head_q;
                default:          rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tail_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= do_read;
            if (push) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // ##################################################
    // serializer.
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= idle;
            tx_q      <= 1'b1;  // line idles high.
            timer_q   <= '0;
            bit_idx_q <= '0;
            head_q    <= '0;
        end else begin
            timer_q <= bit_done ? '0 : timer_q + 1'b1;
            case (state_q)
                idle: begin
                    timer_q <= '0;
                    if (tail_q != head_q) begin
                        state_q <= start_bit;
                        tx_q    <= 1'b0;
                        shift_q <= fifo_q[head_q[ptr_bits-1:0]];
                    end
                end
                start_bit: begin
                    if (bit_done) begin
                        state_q   <= data_bits;
                        tx_q      <= shift_q[0];  // lsb first.
                        shift_q   <= shift_q >> 1;
                        bit_idx_q <= '0;
                    end
                end
                data_bits: begin
                    if (bit_done) begin
                        if (bit_idx_q == idx_w'(n_data - 1)) begin
                            state_q <= stop_bit;
                            tx_q    <= 1'b1;
                        end else begin
                            tx_q      <= shift_q[0];
                            shift_q   <= shift_q >> 1;
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                default: begin  // stop bit.
                    if (bit_done) begin
                        head_q <= head_q + 1'b1;
                        // back to back frames skip idle.
                        if (tail_q != head_q + 1'b1) begin
                            state_q <= start_bit;
                            tx_q    <= 1'b0;
                            shift_q <= fifo_q[head_q[ptr_bits-1:0] + 1'b1];
                        end else begin
                            state_q <= idle;
                        end
                    end
                end
            endcase
        end
    end

    assign uart_tx = tx_q;

    // only a push into a full queue is held off.
    assign rsp = '{ready: !(cmd.write && (cmd.addr == '0) && full),
                   rdata: rdata_q, rdata_valid: valid_q};

endmodule

// File: hdl/ram_store.sv
module ram_store import mmio_pkg::*; #(
    parameter int mem_words = 1024
) (
    input  logic     clk,
    input  logic     rst_n,
    input  bus_cmd_t cmd,
    output bus_rsp_t rsp
);

    // depth is a power of two, so the index slice wraps on its own.
    localparam int addr_bits = $clog2(mem_words);

    word_t                mem_q [mem_words];
    logic [addr_bits-1:0] word_idx;
    logic                 do_write;
    logic                 do_read;
    word_t                rdata_q;
    logic                 valid_q;

    assign word_idx = cmd.addr[addr_bits+1:2];  // byte to word.
    assign do_write = cmd.start && cmd.write;
    assign do_read  = cmd.start && !cmd.write;

    // ##################################################
    // storage.
    // ##################################################

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem_q[word_idx] <= cmd.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (do_read) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    // ##################################################
    // read response.
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= do_read;  // one cycle after accept.
        end
    end

    // never refuses a command.
    assign rsp = '{ready: 1'b1, rdata: rdata_q, rdata_valid: valid_q};

endmodule

// File: hdl/mem_map_decoder.sv
module mem_map_decoder import mmio_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,

    input  bus_cmd_t host_cmd,
    output bus_rsp_t host_rsp,

    output bus_cmd_t ram_cmd,
    output bus_cmd_t tx_cmd,
    output bus_cmd_t rx_cmd,

    input  bus_rsp_t ram_rsp,
    input  bus_rsp_t tx_rsp,
    input  bus_rsp_t rx_rsp
);

    logic     in_tx;
    logic     in_rx;
    target_e  sel;
    target_e  rd_tgt_q;      // target of the read in flight.
    bus_rsp_t sel_rsp;
    bus_rsp_t rd_rsp;
    logic     rd_accept;

    // ##################################################
    // address decode.
    // ##################################################

    assign in_tx = (host_cmd.addr >= uart_tx_base) &&
                   (host_cmd.addr <= uart_tx_base + uart_tx_head_ofs);
    assign in_rx = (host_cmd.addr >= uart_rx_base) &&
                   (host_cmd.addr <= uart_rx_base + uart_rx_count_ofs);

    always_comb begin
        if (in_tx) begin
            sel = tgt_uart_tx;
        end else if (in_rx) begin
            sel = tgt_uart_rx;
        end else begin
            sel = tgt_ram;  // everything else.
        end
    end

    // strobes only reach the selected target.
    always_comb begin
        ram_cmd = host_cmd;
        tx_cmd  = host_cmd;
        rx_cmd  = host_cmd;
        tx_cmd.addr = host_cmd.addr - uart_tx_base;
        rx_cmd.addr = host_cmd.addr - uart_rx_base;
        if (sel != tgt_ram) begin
            ram_cmd.start = 1'b0;
            ram_cmd.write = 1'b0;
        end
        if (sel != tgt_uart_tx) begin
            tx_cmd.start = 1'b0;
            tx_cmd.write = 1'b0;
        end
        if (sel != tgt_uart_rx) begin
            rx_cmd.start = 1'b0;
            rx_cmd.write = 1'b0;
        end
    end

    // ##################################################
    // response steering.
    // ##################################################

    always_comb begin
        case (sel)
            tgt_uart_tx: sel_rsp = tx_rsp;
            tgt_uart_rx: sel_rsp = rx_rsp;
            default:     sel_rsp = ram_rsp;
        endcase
    end

    always_comb begin
        case (rd_tgt_q)
            tgt_uart_tx: rd_rsp = tx_rsp;
            tgt_uart_rx: rd_rsp = rx_rsp;
            default:     rd_rsp = ram_rsp;
        endcase
    end

    assign rd_accept = host_cmd.start && !host_cmd.write && sel_rsp.ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_tgt_q <= tgt_ram;
        end else if (rd_accept) begin
            rd_tgt_q <= sel;  // address may move on next cycle.
        end
    end

    assign host_rsp = '{ready: sel_rsp.ready, rdata: rd_rsp.rdata,
                        rdata_valid: rd_rsp.rdata_valid};

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // start bit, eight data bits, one stop bit.
    localparam int frame_bits = 10;

    // shared by the tx and rx state machines.
    typedef enum logic [1:0] {
        idle,
        start_bit,
        data_bits,
        stop_bit
    } line_state_e;

endpackage

// File: hdl/mmio_pkg.sv
package mmio_pkg;

    // ##################################################
    // bus word types.
    // ##################################################

    typedef logic [31:0] word_t;  // data word.
    typedef logic [31:0] addr_t;  // byte address.

    // command from the bus master, held until accepted.
    typedef struct packed {
        logic  start;
        logic  write;
        addr_t addr;
        word_t wdata;
    } bus_cmd_t;

    // response back to the master.
    typedef struct packed {
        logic  ready;        // level, target can take the command.
        word_t rdata;
        logic  rdata_valid;  // one-cycle pulse per read.
    } bus_rsp_t;

    typedef enum logic [1:0] {
        tgt_ram,
        tgt_uart_tx,
        tgt_uart_rx
    } target_e;

    // ##################################################
    // address map.
    // ##################################################

    // tx queue window.
    localparam addr_t uart_tx_base      = 32'hff000000;  // push low byte.
    localparam addr_t uart_tx_tail_ofs  = 32'h100;       // bytes pushed.
    localparam addr_t uart_tx_head_ofs  = 32'h104;       // bytes sent.

    // rx buffer window, one byte per word.
    localparam addr_t uart_rx_base      = 32'hff000200;
    localparam addr_t uart_rx_tail_ofs  = 32'h400;       // write index.
    localparam addr_t uart_rx_count_ofs = 32'h404;       // bytes received.

endpackage
